// ==== cpu_core.f ====
src/cpu_pkg.sv
src/alu.sv
src/instr_fetch.sv
src/instr_decode.sv
src/execute.sv
src/cpu_core.sv
test/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_core_tb \
    --Mdir obj_dir -f cpu_core.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build of the simulation failed"
    exit 1
fi

./obj_dir/Vcpu_core_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
exit 0

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_mode_e              i_mode,
    input  logic [cpu_pkg::WORD_W-1:0]      i_l,
    input  logic [cpu_pkg::WORD_W-1:0]      i_r,
    input  logic                            i_carry_in,
    output logic [cpu_pkg::WORD_W-1:0]      o_result,
    output logic                            o_carry,
    output logic                            o_zero,
    output logic                            o_neg
);
    import cpu_pkg::*;

    logic [WORD_W:0] sum;
    logic [WORD_W:0] cin_ext;

    assign cin_ext = (WORD_W + 1)'(i_carry_in);

    always_comb begin
        case (i_mode)
            ALU_L_PASS: sum = {1'b0, i_l};
            ALU_R_PASS: sum = {1'b0, i_r};
            ALU_ADD:    sum = {1'b0, i_l} + {1'b0, i_r} + cin_ext;
            // Carry out set means no borrow
            ALU_SUB:    sum = {1'b0, i_l} + {1'b0, ~i_r} + cin_ext;
            default:    sum = '0;
        endcase
    end

    assign o_result = sum[WORD_W-1:0];
    assign o_carry = sum[WORD_W];
    assign o_zero = (sum[WORD_W-1:0] == '0);
    assign o_neg = sum[WORD_W-1];

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int PC_W = cpu_pkg::PC_W_DEFAULT
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_halt,
    output logic [PC_W-1:0]                o_imem_addr,
    output logic                           o_imem_req,
    input  logic [cpu_pkg::INSTR_W-1:0]    i_imem_data,
    input  logic                           i_imem_valid,
    output logic                           o_wb_valid,
    output logic [cpu_pkg::REG_SEL_W-1:0]  o_wb_reg,
    output logic [cpu_pkg::WORD_W-1:0]     o_wb_data,
    output logic [cpu_pkg::FLAGS_W-1:0]    o_flags
);
    import cpu_pkg::*;

    // Fetch to decode
    logic                  f_submit;
    logic [INSTR_L_W-1:0]  f_instr_l;
    logic [WORD_W-1:0]     f_imm;
    logic                  f_pred;
    logic [PC_W-1:0]       f_pc;
    logic                  d_ready;

    // Decode to execute
    logic                  d_submit;
    logic [WORD_W-1:0]     d_imm;
    logic                  d_pred;
    logic [PC_W-1:0]       d_pc;
    logic                  d_r_bus_imm;
    alu_mode_e             d_alu_mode;
    logic                  d_alu_carry_en;
    logic                  d_alu_flags_ie;
    logic [REG_SEL_W-1:0]  d_l_reg_sel;
    logic [REG_SEL_W-1:0]  d_r_reg_sel;
    logic [REG_CNT-1:0]    d_rf_ie;
    logic                  d_is_jump;
    jump_cond_e            d_jump_cond;
    logic                  x_ready;

    logic                  flush;
    logic [PC_W-1:0]       redirect_pc;

    instr_fetch #(.PC_W(PC_W)) fetch_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .o_imem_addr   (o_imem_addr),
        .o_imem_req    (o_imem_req),
        .i_imem_data   (i_imem_data),
        .i_imem_valid  (i_imem_valid),
        .i_next_ready  (d_ready),
        .o_submit      (f_submit),
        .o_instr_l     (f_instr_l),
        .o_imm         (f_imm),
        .o_jmp_pred    (f_pred),
        .o_pc          (f_pc),
        .i_flush       (flush),
        .i_redirect_pc (redirect_pc)
    );

    instr_decode #(.PC_W(PC_W)) decode_i (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_instr_l       (f_instr_l),
        .i_imm_pass      (f_imm),
        .o_imm_pass      (d_imm),
        .i_jmp_pred_pass (f_pred),
        .o_jmp_pred_pass (d_pred),
        .i_pc_pass       (f_pc),
        .o_pc_pass       (d_pc),
        .i_next_ready    (x_ready),
        .i_submit        (f_submit),
        .o_ready         (d_ready),
        .o_submit        (d_submit),
        .i_flush         (flush),
        .oc_r_bus_imm    (d_r_bus_imm),
        .oc_alu_mode     (d_alu_mode),
        .oc_alu_carry_en (d_alu_carry_en),
        .oc_alu_flags_ie (d_alu_flags_ie),
        .oc_l_reg_sel    (d_l_reg_sel),
        .oc_r_reg_sel    (d_r_reg_sel),
        .oc_rf_ie        (d_rf_ie),
        .oc_is_jump      (d_is_jump),
        .oc_jump_cond    (d_jump_cond)
    );

    execute #(.PC_W(PC_W)) execute_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_halt         (i_halt),
        .i_submit       (d_submit),
        .o_ready        (x_ready),
        .i_r_bus_imm    (d_r_bus_imm),
        .i_alu_mode     (d_alu_mode),
        .i_alu_carry_en (d_alu_carry_en),
        .i_alu_flags_ie (d_alu_flags_ie),
        .i_l_reg_sel    (d_l_reg_sel),
        .i_r_reg_sel    (d_r_reg_sel),
        .i_rf_ie        (d_rf_ie),
        .i_is_jump      (d_is_jump),
        .i_jump_cond    (d_jump_cond),
        .i_imm          (d_imm),
        .i_jmp_pred     (d_pred),
        .i_pc           (d_pc),
        .o_flush        (flush),
        .o_redirect_pc  (redirect_pc),
        .o_wb_valid     (o_wb_valid),
        .o_wb_reg       (o_wb_reg),
        .o_wb_data      (o_wb_data),
        .o_flags        (o_flags)
    );

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 16;
    localparam int INSTR_W = 32;
    localparam int INSTR_L_W = INSTR_W - WORD_W;
    localparam int REG_CNT = 8;
    localparam int REG_SEL_W = 3;
    localparam int PC_W_DEFAULT = 10;

    // Low half of the instruction word
    localparam int OPC_LSB = 0;
    localparam int OPC_W = 7;
    localparam int DST_LSB = 7;
    localparam int ST_LSB = 10;
    localparam int ND_LSB = 13;
    localparam int COND_LSB = 7;
    localparam int COND_W = 4;

    // Immediate fills the high half
    localparam int IMM_LSB = INSTR_L_W;

    localparam int ALU_MODE_W = 2;

    // Flag register bit positions
    localparam int FLAGS_W = 3;
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;

    typedef enum logic [OPC_W-1:0] {
        OPC_NOP = 7'h0,
        OPC_MOV = 7'h1,
        OPC_LDI = 7'h4,
        OPC_ADD = 7'h7,
        OPC_ADI = 7'h8,
        OPC_ADC = 7'h9,
        OPC_SUB = 7'ha,
        OPC_SUC = 7'hb,
        OPC_CMP = 7'hc,
        OPC_CMI = 7'hd,
        OPC_JMP = 7'he
    } opcode_e;

    typedef enum logic [ALU_MODE_W-1:0] {
        ALU_L_PASS = 2'd0,
        ALU_R_PASS = 2'd1,
        ALU_ADD = 2'd2,
        ALU_SUB = 2'd3
    } alu_mode_e;

    typedef enum logic [COND_W-1:0] {
        JC_ALWAYS = 4'd0,
        JC_Z = 4'd1,
        JC_NZ = 4'd2,
        JC_C = 4'd3,
        JC_NC = 4'd4,
        JC_N = 4'd5,
        JC_NN = 4'd6
    } jump_cond_e;

endpackage

`default_nettype wire

// ==== src/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute #(
    parameter int PC_W = cpu_pkg::PC_W_DEFAULT
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_halt,
    input  logic                           i_submit,
    output logic                           o_ready,
    input  logic                           i_r_bus_imm,
    input  cpu_pkg::alu_mode_e             i_alu_mode,
    input  logic                           i_alu_carry_en,
    input  logic                           i_alu_flags_ie,
    input  logic [cpu_pkg::REG_SEL_W-1:0]  i_l_reg_sel,
    input  logic [cpu_pkg::REG_SEL_W-1:0]  i_r_reg_sel,
    input  logic [cpu_pkg::REG_CNT-1:0]    i_rf_ie,
    input  logic                           i_is_jump,
    input  cpu_pkg::jump_cond_e            i_jump_cond,
    input  logic [cpu_pkg::WORD_W-1:0]     i_imm,
    input  logic                           i_jmp_pred,
    input  logic [PC_W-1:0]                i_pc,
    output logic                           o_flush,
    output logic [PC_W-1:0]                o_redirect_pc,
    output logic                           o_wb_valid,
    output logic [cpu_pkg::REG_SEL_W-1:0]  o_wb_reg,
    output logic [cpu_pkg::WORD_W-1:0]     o_wb_data,
    output logic [cpu_pkg::FLAGS_W-1:0]    o_flags
);
    import cpu_pkg::*;

    logic [WORD_W-1:0]     regs [REG_CNT];
    logic                  stalled;
    logic                  fire;
    logic                  carry_in;
    logic                  cond_true;
    logic [WORD_W-1:0]     l_val;
    logic [WORD_W-1:0]     r_val;
    logic [WORD_W-1:0]     alu_result;
    logic                  alu_carry;
    logic                  alu_zero;
    logic                  alu_neg;
    logic [REG_SEL_W-1:0]  dst_sel;

    // Decode keeps its outputs stable, so a submit during halt waits in place
    assign fire = (i_submit | stalled) & ~i_halt & ~o_flush;
    assign o_ready = ~i_halt & ~stalled;

    assign l_val = regs[i_l_reg_sel];
    assign r_val = i_r_bus_imm ? i_imm : regs[i_r_reg_sel];
    assign carry_in = i_alu_carry_en ? o_flags[FLAG_C] : (i_alu_mode == ALU_SUB);

    alu alu_i (
        .i_mode     (i_alu_mode),
        .i_l        (l_val),
        .i_r        (r_val),
        .i_carry_in (carry_in),
        .o_result   (alu_result),
        .o_carry    (alu_carry),
        .o_zero     (alu_zero),
        .o_neg      (alu_neg)
    );

    always_comb begin
        case (i_jump_cond)
            JC_ALWAYS: cond_true = 1'b1;
            JC_Z:      cond_true = o_flags[FLAG_Z];
            JC_NZ:     cond_true = ~o_flags[FLAG_Z];
            JC_C:      cond_true = o_flags[FLAG_C];
            JC_NC:     cond_true = ~o_flags[FLAG_C];
            JC_N:      cond_true = o_flags[FLAG_N];
            JC_NN:     cond_true = ~o_flags[FLAG_N];
            default:   cond_true = 1'b0;
        endcase
    end

    // One-hot write enable to register index
    always_comb begin
        dst_sel = '0;
        for (int i = 0; i < REG_CNT; i++) begin
            if (i_rf_ie[i]) begin
                dst_sel = REG_SEL_W'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stalled <= 1'b0;
            o_flush <= 1'b0;
            o_wb_valid <= 1'b0;
            o_flags <= '0;
        end else begin
            stalled <= (i_submit | stalled) & i_halt & ~o_flush;
            o_flush <= fire & i_is_jump & (cond_true != i_jmp_pred);
            o_wb_valid <= fire & (|i_rf_ie);
            if (fire && i_alu_flags_ie) begin
                o_flags[FLAG_Z] <= alu_zero;
                o_flags[FLAG_C] <= alu_carry;
                o_flags[FLAG_N] <= alu_neg;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (fire) begin
            for (int i = 0; i < REG_CNT; i++) begin
                if (i_rf_ie[i]) begin
                    regs[i] <= alu_result;
                end
            end
            o_wb_reg <= dst_sel;
            o_wb_data <= alu_result;
            o_redirect_pc <= cond_true ? PC_W'(i_imm) : i_pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode #(
    parameter int PC_W = cpu_pkg::PC_W_DEFAULT
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic [cpu_pkg::INSTR_L_W-1:0]  i_instr_l,
    input  logic [cpu_pkg::WORD_W-1:0]     i_imm_pass,
    output logic [cpu_pkg::WORD_W-1:0]     o_imm_pass,
    input  logic                           i_jmp_pred_pass,
    output logic                           o_jmp_pred_pass,
    input  logic [PC_W-1:0]                i_pc_pass,
    output logic [PC_W-1:0]                o_pc_pass,
    input  logic                           i_next_ready,
    input  logic                           i_submit,
    output logic                           o_ready,
    output logic                           o_submit,
    input  logic                           i_flush,
    output logic                           oc_r_bus_imm,
    output cpu_pkg::alu_mode_e             oc_alu_mode,
    output logic                           oc_alu_carry_en,
    output logic                           oc_alu_flags_ie,
    output logic [cpu_pkg::REG_SEL_W-1:0]  oc_l_reg_sel,
    output logic [cpu_pkg::REG_SEL_W-1:0]  oc_r_reg_sel,
    output logic [cpu_pkg::REG_CNT-1:0]    oc_rf_ie,
    output logic                           oc_is_jump,
    output cpu_pkg::jump_cond_e            oc_jump_cond
);
    import cpu_pkg::*;

    logic                  buf_valid;
    logic [INSTR_L_W-1:0]  buf_instr_l;
    logic [WORD_W-1:0]     buf_imm;
    logic                  buf_pred;
    logic [PC_W-1:0]       buf_pc;

    // Buffered word has priority over the input
    logic [INSTR_L_W-1:0]  src_instr_l;
    logic [WORD_W-1:0]     src_imm;
    logic                  src_pred;
    logic [PC_W-1:0]       src_pc;

    opcode_e               opcode;
    logic [REG_SEL_W-1:0]  reg_dst;
    logic [REG_SEL_W-1:0]  reg_st;
    logic [REG_SEL_W-1:0]  reg_nd;

    logic                  c_r_bus_imm;
    alu_mode_e             c_alu_mode;
    logic                  c_alu_carry_en;
    logic                  c_alu_flags_ie;
    logic [REG_SEL_W-1:0]  c_l_reg_sel;
    logic [REG_SEL_W-1:0]  c_r_reg_sel;
    logic [REG_CNT-1:0]    c_rf_ie;
    logic                  c_is_jump;
    jump_cond_e            c_jump_cond;

    assign src_instr_l = buf_valid ? buf_instr_l : i_instr_l;
    assign src_imm = buf_valid ? buf_imm : i_imm_pass;
    assign src_pred = buf_valid ? buf_pred : i_jmp_pred_pass;
    assign src_pc = buf_valid ? buf_pc : i_pc_pass;

    assign opcode = opcode_e'(src_instr_l[OPC_LSB +: OPC_W]);
    assign reg_dst = src_instr_l[DST_LSB +: REG_SEL_W];
    assign reg_st = src_instr_l[ST_LSB +: REG_SEL_W];
    assign reg_nd = src_instr_l[ND_LSB +: REG_SEL_W];

    always_comb begin
        c_r_bus_imm = 1'b0;
        c_alu_mode = ALU_L_PASS;
        c_alu_carry_en = 1'b0;
        c_alu_flags_ie = 1'b0;
        c_l_reg_sel = reg_st;
        c_r_reg_sel = reg_nd;
        c_rf_ie = '0;
        c_is_jump = 1'b0;
        c_jump_cond = JC_ALWAYS;
        case (opcode)
            OPC_MOV: begin
                c_rf_ie[reg_dst] = 1'b1;
            end
            OPC_LDI: begin
                c_alu_mode = ALU_R_PASS;
                c_r_bus_imm = 1'b1;
                c_rf_ie[reg_dst] = 1'b1;
            end
            OPC_ADD, OPC_ADC, OPC_SUB, OPC_SUC: begin
                c_alu_mode = (opcode == OPC_ADD || opcode == OPC_ADC) ? ALU_ADD : ALU_SUB;
                c_alu_carry_en = (opcode == OPC_ADC || opcode == OPC_SUC);
                c_alu_flags_ie = 1'b1;
                c_rf_ie[reg_dst] = 1'b1;
            end
            OPC_ADI: begin
                c_alu_mode = ALU_ADD;
                c_r_bus_imm = 1'b1;
                c_alu_flags_ie = 1'b1;
                c_rf_ie[reg_dst] = 1'b1;
            end
            OPC_CMP, OPC_CMI: begin
                // Flags only, no register write
                c_alu_mode = ALU_SUB;
                c_r_bus_imm = (opcode == OPC_CMI);
                c_alu_flags_ie = 1'b1;
            end
            OPC_JMP: begin
                c_alu_mode = ALU_R_PASS;
                c_r_bus_imm = 1'b1;
                c_is_jump = 1'b1;
                c_jump_cond = jump_cond_e'(src_instr_l[COND_LSB +: COND_W]);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
            o_ready <= 1'b1;
            buf_valid <= 1'b0;
        end else if (i_flush) begin
            o_submit <= 1'b0;
            o_ready <= 1'b1;
            buf_valid <= 1'b0;
        end else begin
            o_submit <= i_next_ready & (i_submit | buf_valid);
            if (i_next_ready && buf_valid) begin
                o_ready <= 1'b1;
                buf_valid <= 1'b0;
            end
            if (i_submit && !i_next_ready) begin
                o_ready <= 1'b0;
                buf_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_submit && !i_next_ready) begin
            buf_instr_l <= i_instr_l;
            buf_imm <= i_imm_pass;
            buf_pred <= i_jmp_pred_pass;
            buf_pc <= i_pc_pass;
        end
        if (i_next_ready && (i_submit || buf_valid)) begin
            o_imm_pass <= src_imm;
            o_jmp_pred_pass <= src_pred;
            o_pc_pass <= src_pc;
            oc_r_bus_imm <= c_r_bus_imm;
            oc_alu_mode <= c_alu_mode;
            oc_alu_carry_en <= c_alu_carry_en;
            oc_alu_flags_ie <= c_alu_flags_ie;
            oc_l_reg_sel <= c_l_reg_sel;
            oc_r_reg_sel <= c_r_reg_sel;
            oc_rf_ie <= c_rf_ie;
            oc_is_jump <= c_is_jump;
            oc_jump_cond <= c_jump_cond;
        end
    end

endmodule

`default_nettype wire

// ==== src/instr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
    parameter int PC_W = cpu_pkg::PC_W_DEFAULT
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    output logic [PC_W-1:0]                o_imem_addr,
    output logic                           o_imem_req,
    input  logic [cpu_pkg::INSTR_W-1:0]    i_imem_data,
    input  logic                           i_imem_valid,
    input  logic                           i_next_ready,
    output logic                           o_submit,
    output logic [cpu_pkg::INSTR_L_W-1:0]  o_instr_l,
    output logic [cpu_pkg::WORD_W-1:0]     o_imm,
    output logic                           o_jmp_pred,
    output logic [PC_W-1:0]                o_pc,
    input  logic                           i_flush,
    input  logic [PC_W-1:0]                i_redirect_pc
);
    import cpu_pkg::*;

    logic [PC_W-1:0] pc;
    logic            pending;
    logic            discard;
    logic            is_jmp;
    logic            pred_taken;
    logic [PC_W-1:0] jmp_target;

    // Static prediction, backward or unconditional is taken
    assign is_jmp = (i_imem_data[OPC_LSB +: OPC_W] == OPC_JMP);
    assign jmp_target = PC_W'(i_imem_data[IMM_LSB +: WORD_W]);
    assign pred_taken = is_jmp &
                        ((i_imem_data[COND_LSB +: COND_W] == JC_ALWAYS) | (jmp_target < pc));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
            pending <= 1'b0;
            discard <= 1'b0;
            o_imem_req <= 1'b0;
            o_submit <= 1'b0;
        end else begin
            o_imem_req <= 1'b0;
            o_submit <= 1'b0;
            if (i_imem_valid) begin
                pending <= 1'b0;
                discard <= 1'b0;
            end
            if (i_flush) begin
                pc <= i_redirect_pc;
                // Word still in flight belongs to the wrong path
                discard <= pending & ~i_imem_valid;
            end else if (i_imem_valid && !discard) begin
                o_submit <= 1'b1;
                pc <= pred_taken ? jmp_target : pc + 1'b1;
            end else if (!pending && !o_submit && i_next_ready) begin
                // Wait one cycle after a submit so decode's ready is current
                o_imem_req <= 1'b1;
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!pending && !o_submit && i_next_ready) begin
            o_imem_addr <= pc;
        end
        if (i_imem_valid) begin
            o_instr_l <= i_imem_data[INSTR_L_W-1:0];
            o_imm <= i_imem_data[IMM_LSB +: WORD_W];
            o_jmp_pred <= pred_taken;
            o_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int PC_W = 10;
    localparam int MEM_DEPTH = 1 << PC_W;
    localparam int NUM_PROGS = 6;
    localparam int NUM_BLOCKS = 14;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int TAIL_CYCLES = 40;
    localparam int MAX_STEPS = 4000;

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_halt;
    logic [PC_W-1:0]       o_imem_addr;
    logic                  o_imem_req;
    logic [INSTR_W-1:0]    i_imem_data;
    logic                  i_imem_valid;
    logic                  o_wb_valid;
    logic [REG_SEL_W-1:0]  o_wb_reg;
    logic [WORD_W-1:0]     o_wb_data;
    logic [FLAGS_W-1:0]    o_flags;

    int                    seed;
    logic [INSTR_W-1:0]    imem [MEM_DEPTH];
    int                    plen;
    logic [REG_SEL_W-1:0]  exp_reg [$];
    logic [WORD_W-1:0]     exp_data [$];
    logic [FLAGS_W-1:0]    exp_flags [$];
    int                    exp_idx;
    int                    model_steps;
    int                    mem_wait;
    logic [PC_W-1:0]       mem_addr;
    int                    halt_left;

    cpu_core #(.PC_W(PC_W)) dut_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_halt       (i_halt),
        .o_imem_addr  (o_imem_addr),
        .o_imem_req   (o_imem_req),
        .i_imem_data  (i_imem_data),
        .i_imem_valid (i_imem_valid),
        .o_wb_valid   (o_wb_valid),
        .o_wb_reg     (o_wb_reg),
        .o_wb_data    (o_wb_data),
        .o_flags      (o_flags)
    );

    always #10 i_clk = ~i_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [INSTR_W-1:0] enc(
        input opcode_e     op,
        input logic [2:0]  dst,
        input logic [2:0]  st,
        input logic [2:0]  nd,
        input logic [15:0] imm
    );
        return {imm, nd, st, dst, op};
    endfunction

    function automatic logic [INSTR_W-1:0] enc_jmp(input jump_cond_e cond, input int target);
        return {16'(target), 5'b0, cond, OPC_JMP};
    endfunction

    function automatic logic cond_holds(input jump_cond_e cond, input logic [FLAGS_W-1:0] f);
        case (cond)
            JC_ALWAYS: return 1'b1;
            JC_Z:      return f[FLAG_Z];
            JC_NZ:     return !f[FLAG_Z];
            JC_C:      return f[FLAG_C];
            JC_NC:     return !f[FLAG_C];
            JC_N:      return f[FLAG_N];
            JC_NN:     return !f[FLAG_N];
            default:   return 1'b0;
        endcase
    endfunction

    task automatic emit(input logic [INSTR_W-1:0] word);
        imem[plen] = word;
        plen++;
    endtask

    // r7 is kept for loop counters, so random ops write r0..r6
    task automatic emit_random_op();
        opcode_e op;
        case (rand_below(10))
            0:       op = OPC_MOV;
            1:       op = OPC_LDI;
            2:       op = OPC_ADD;
            3:       op = OPC_ADI;
            4:       op = OPC_ADC;
            5:       op = OPC_SUB;
            6:       op = OPC_SUC;
            7:       op = OPC_CMP;
            8:       op = OPC_CMI;
            default: op = OPC_NOP;
        endcase
        emit(enc(op, 3'(rand_below(7)), 3'(rand_below(8)), 3'(rand_below(8)),
                 16'($random(seed))));
    endtask

    task automatic build_program();
        int skip;
        int top;
        // Unused words jump to themselves
        for (int a = 0; a < MEM_DEPTH; a++) begin
            imem[a] = enc_jmp(JC_ALWAYS, a);
        end
        plen = 0;
        for (int r = 0; r < REG_CNT; r++) begin
            emit(enc(OPC_LDI, 3'(r), 3'd0, 3'd0, 16'($random(seed))));
        end
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            case (rand_below(4))
                0: begin
                    repeat (1 + rand_below(3)) emit_random_op();
                end
                1: begin
                    // Carry chain with guaranteed overflow and borrow
                    // r2 stays below r1 so r2 - r1 borrows
                    emit(enc(OPC_LDI, 3'd1, 3'd0, 3'd0, 16'hf000 | 16'($random(seed))));
                    emit(enc(OPC_LDI, 3'd2, 3'd0, 3'd0,
                             16'h8000 | (16'($random(seed)) & 16'h6fff)));
                    emit(enc(OPC_ADD, 3'd3, 3'd1, 3'd2, 16'h0));
                    emit(enc(OPC_ADC, 3'd4, 3'd1, 3'd2, 16'h0));
                    emit(enc(OPC_SUB, 3'd5, 3'd2, 3'd1, 16'h0));
                    emit(enc(OPC_SUC, 3'd6, 3'd2, 3'd1, 16'h0));
                    emit(enc(OPC_CMI, 3'd0, 3'd6, 3'd0, 16'($random(seed))));
                    emit(enc(OPC_ADC, 3'd0, 3'd5, 3'd6, 16'h0));
                end
                2: begin
                    // Forward conditional jump over a few ops
                    skip = 1 + rand_below(3);
                    emit(enc(OPC_CMI, 3'd0, 3'(rand_below(8)), 3'd0, 16'($random(seed))));
                    emit(enc_jmp(jump_cond_e'(4'(1 + rand_below(6))), plen + 1 + skip));
                    repeat (skip) emit_random_op();
                end
                default: begin
                    // Counted loop closed by a backward NZ jump
                    emit(enc(OPC_LDI, 3'd7, 3'd0, 3'd0, 16'(2 + rand_below(4))));
                    top = plen;
                    repeat (1 + rand_below(3)) emit_random_op();
                    emit(enc(OPC_ADI, 3'd7, 3'd7, 3'd0, 16'hffff));
                    emit(enc_jmp(JC_NZ, top));
                end
            endcase
        end
        emit(enc_jmp(JC_ALWAYS, plen));
    endtask

    // Architectural interpreter that lists the expected write-backs
    task automatic run_model();
        logic [WORD_W-1:0]   regs [REG_CNT];
        logic [FLAGS_W-1:0]  flags;
        logic [INSTR_W-1:0]  w;
        opcode_e             op;
        logic [PC_W-1:0]     pc;
        logic [PC_W-1:0]     next_pc;
        logic [2:0]          dst;
        logic [2:0]          st;
        logic [2:0]          nd;
        logic [WORD_W-1:0]   imm;
        logic [WORD_W-1:0]   rhs;
        logic [WORD_W-1:0]   res;
        int                  full;
        logic                carry;
        logic                wr;
        logic                setf;
        logic                done;
        exp_reg.delete();
        exp_data.delete();
        exp_flags.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        flags = '0;
        pc = '0;
        model_steps = 0;
        done = 1'b0;
        while (!done) begin
            assert (model_steps < MAX_STEPS)
                else report_failure("Reference model did not reach the end of the program");
            w = imem[pc];
            op = opcode_e'(w[6:0]);
            dst = w[9:7];
            st = w[12:10];
            nd = w[15:13];
            imm = w[31:16];
            next_pc = pc + 1'b1;
            wr = 1'b0;
            setf = 1'b0;
            carry = 1'b0;
            full = 0;
            model_steps++;
            case (op)
                OPC_MOV: begin
                    wr = 1'b1;
                    full = int'(regs[st]);
                end
                OPC_LDI: begin
                    wr = 1'b1;
                    full = int'(imm);
                end
                OPC_ADD, OPC_ADI, OPC_ADC: begin
                    rhs = (op == OPC_ADI) ? imm : regs[nd];
                    full = int'(regs[st]) + int'(rhs)
                           + ((op == OPC_ADC) ? int'(flags[FLAG_C]) : 0);
                    carry = (full > 32'h0000_ffff);
                    wr = 1'b1;
                    setf = 1'b1;
                end
                OPC_SUB, OPC_SUC, OPC_CMP, OPC_CMI: begin
                    rhs = (op == OPC_CMI) ? imm : regs[nd];
                    // Borrow in for SUC is a clear carry flag
                    full = int'(regs[st]) - int'(rhs)
                           - ((op == OPC_SUC) ? int'(!flags[FLAG_C]) : 0);
                    carry = (full >= 0);
                    wr = (op == OPC_SUB) || (op == OPC_SUC);
                    setf = 1'b1;
                end
                OPC_JMP: begin
                    if (cond_holds(jump_cond_e'(w[10:7]), flags)) begin
                        next_pc = PC_W'(imm);
                        done = (next_pc == pc);
                    end
                end
                default: begin
                end
            endcase
            res = 16'(full);
            if (setf) begin
                flags[FLAG_Z] = (res == '0);
                flags[FLAG_C] = carry;
                flags[FLAG_N] = res[WORD_W-1];
            end
            if (wr) begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_data.push_back(res);
                exp_flags.push_back(flags);
            end
            pc = next_pc;
        end
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        #1;
        i_rst = 1'b1;
        i_halt = 1'b0;
        i_imem_valid = 1'b0;
        mem_wait = 0;
        halt_left = 0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
    endtask

    // Answers one request after 1 to 3 cycles
    task automatic drive_memory();
        i_imem_valid = 1'b0;
        if (mem_wait > 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
                i_imem_valid = 1'b1;
                i_imem_data = imem[mem_addr];
            end
        end
        if (o_imem_req) begin
            mem_addr = o_imem_addr;
            mem_wait = 1 + rand_below(3);
        end
    endtask

    task automatic drive_halt();
        if (halt_left > 0) begin
            halt_left--;
            i_halt = 1'b1;
        end else if (rand_below(30) == 0) begin
            halt_left = 1 + rand_below(5);
            i_halt = 1'b1;
        end else begin
            i_halt = 1'b0;
        end
    endtask

    task automatic check_writeback(input int prog);
        string name;
        name = $sformatf("prog%0d_wb%0d", prog, exp_idx);
        assert (exp_idx < exp_reg.size())
            else report_failure($sformatf(
                "Program %0d wrote r%0d after its last expected write-back",
                prog, o_wb_reg));
        assert (o_wb_reg == exp_reg[exp_idx])
            else report_failure($sformatf("FAILED %s register: expected r%0d, actual r%0d",
                                          name, exp_reg[exp_idx], o_wb_reg));
        assert (o_wb_data == exp_data[exp_idx])
            else report_failure($sformatf("FAILED %s data: expected %h, actual %h",
                                          name, exp_data[exp_idx], o_wb_data));
        assert (o_flags == exp_flags[exp_idx])
            else report_failure($sformatf("FAILED %s flags: expected %b, actual %b",
                                          name, exp_flags[exp_idx], o_flags));
        exp_idx++;
    endtask

    task automatic run_program(input int prog);
        int cycles;
        int idle;
        int limit;
        limit = CYCLES_PER_INSTR * model_steps + TAIL_CYCLES;
        exp_idx = 0;
        cycles = 0;
        idle = 0;
        while (exp_idx < exp_reg.size() || idle < TAIL_CYCLES) begin
            @(posedge i_clk);
            #1;
            cycles++;
            if (cycles > limit) begin
                report_failure($sformatf(
                    "Timeout: program %0d retired %0d of %0d write-backs in %0d cycles",
                    prog, exp_idx, exp_reg.size(), limit));
            end
            // i_halt still holds the value sampled at this edge
            assert (!(i_halt && o_wb_valid))
                else report_failure($sformatf(
                    "Program %0d: write-back while execute was halted", prog));
            if (o_wb_valid) begin
                check_writeback(prog);
            end
            if (exp_idx >= exp_reg.size()) begin
                idle++;
            end
            drive_memory();
            drive_halt();
        end
        i_halt = 1'b0;
    endtask

    initial begin
        seed = 32'h5d98_41a6;
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_halt = 1'b0;
        i_imem_data = '0;
        i_imem_valid = 1'b0;
        mem_addr = '0;
        mem_wait = 0;
        halt_left = 0;
        for (int prog = 0; prog < NUM_PROGS; prog++) begin
            build_program();
            run_model();
            apply_reset();
            run_program(prog);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
